// File: map_draw_top.f
+incdir+common
common/map_draw_pkg.sv
design/map_memory.sv
design/frame_buffer.sv
draw_map/draw_map.sv
design/map_draw_top.sv
test/tb_map_draw.sv

// File: Bender.yml
package:
  name: map_draw

export_include_dirs:
  - common

sources:
  - files:
      - common/map_draw_pkg.sv
      - design/map_memory.sv
      - design/frame_buffer.sv
      - draw_map/draw_map.sv
      - design/map_draw_top.sv
  - target: test
    files:
      - test/tb_map_draw.sv

// File: test/tb_map_draw.sv
`timescale 1ns/10ps

`include "map_draw_settings.svh"

module tb_map_draw
	import map_draw_pkg::*;
;

	localparam int MAP_WORDS   = `MAP_COUNT * `FRAME_PIXELS;
	localparam int COPY_LIMIT  = `FRAME_PIXELS * 16;  // Worst case per copy with reads.
	localparam int CYCLE_LIMIT = 20000;               // Four copies plus loads and readback.

	logic                 clk;
	logic                 rst_n;
	map_wr_t              map_wr;
	logic                 start;
	logic [`MAP_AW-1:0]   base_addr;
	logic                 done;
	frame_rd_t            frame_rd;
	pixel_t               frame_rd_data;

	pixel_t map_model [MAP_WORDS];  // Expected map memory contents.

	integer seed;
	int     error_count;
	int     test_count;
	int     test_fails;
	int     done_count;
	int     cycle_count;

	map_draw_top i_dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.map_wr        (map_wr),
		.start         (start),
		.base_addr     (base_addr),
		.done          (done),
		.frame_rd      (frame_rd),
		.frame_rd_data (frame_rd_data)
	);

	// ####################################################################
	// Clock, done counter and watchdog
	// ####################################################################

	always #4 clk = ~clk;

	always @(posedge clk) begin
		if (done === 1'b1) begin
			done_count <= done_count + 1;
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Run stopped: no end of test after %0d clock cycles", CYCLE_LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

	// ####################################################################
	// Helper tasks
	// ####################################################################

	task automatic check_value(input logic [`PIX_W-1:0] actual,
	                           input logic [`PIX_W-1:0] expected,
	                           input string what);
		if (actual !== expected) begin
			$display("FAIL %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
			error_count++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		test_count++;
		if (error_count > errors_before) begin
			test_fails++;
			$display("Test %0d %s: FAIL", test_count, name);
		end else begin
			$display("Test %0d %s: PASS", test_count, name);
		end
	endtask

	task automatic load_words(input int first, input int count);
		pixel_t word;
		for (int a = first; a < first + count; a++) begin
			word = pixel_t'($random(seed));
			if (word == map_model[a]) begin
				word = ~word;  // Every word must change.
			end
			map_model[a] = word;
			map_wr.en    = 1'b1;
			map_wr.addr  = `MAP_AW'(a);
			map_wr.data  = word;
			@(negedge clk);
		end
		map_wr.en = 1'b0;
		@(negedge clk);
	endtask

	// Starts a copy and waits for done, with optional display reads and restart.
	task automatic copy_map(input int map_idx, input int read_pct, input bit restart,
	                        output int dones);
		int first_done;
		int cycles;
		int other;
		first_done = done_count;
		cycles     = 0;
		other      = (map_idx + 1) % `MAP_COUNT;
		start      = 1'b1;
		base_addr  = `MAP_AW'(map_idx * `FRAME_PIXELS);
		@(negedge clk);
		start = 1'b0;
		while (done_count == first_done && cycles < COPY_LIMIT) begin
			if (read_pct > 0) begin
				frame_rd.en   = ({$random(seed)} % 100) < read_pct;
				frame_rd.addr = `FRAME_AW'({$random(seed)} % `FRAME_PIXELS);
			end
			if (restart && cycles == 40) begin
				start     = 1'b1;  // Must be ignored while busy.
				base_addr = `MAP_AW'(other * `FRAME_PIXELS);
			end else begin
				start = 1'b0;
			end
			@(negedge clk);
			cycles++;
		end
		start       = 1'b0;
		frame_rd.en = 1'b0;
		if (done_count == first_done) begin
			$display("Copy of map %0d did not finish within %0d cycles", map_idx, COPY_LIMIT);
			error_count++;
		end
		repeat (20) @(negedge clk);  // Catch any extra done.
		dones = done_count - first_done;
	endtask

	task automatic verify_frame(input int map_idx);
		int base;
		base          = map_idx * `FRAME_PIXELS;
		frame_rd.en   = 1'b1;
		frame_rd.addr = '0;
		for (int a = 0; a < `FRAME_PIXELS; a++) begin
			@(negedge clk);
			check_value(frame_rd_data, map_model[base + a],
			            $sformatf("frame word %0d of map %0d", a, map_idx));
			if (a + 1 < `FRAME_PIXELS) begin
				frame_rd.addr = `FRAME_AW'(a + 1);
			end else begin
				frame_rd.en = 1'b0;
			end
		end
		@(negedge clk);
	endtask

	// ####################################################################
	// Test sequence
	// ####################################################################

	initial begin
		int errs;
		int dones;
		clk         = 1'b0;
		rst_n       = 1'b0;
		map_wr      = '0;
		start       = 1'b0;
		base_addr   = '0;
		frame_rd    = '0;
		seed        = 32'h8a82a0e9;
		error_count = 0;
		test_count  = 0;
		test_fails  = 0;
		done_count  = 0;
		cycle_count = 0;
		for (int a = 0; a < MAP_WORDS; a++) begin
			map_model[a] = '0;
		end

		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		// Reset values.
		errs = error_count;
		check_value(done, 1'b0, "done after reset");
		check_value(frame_rd_data, '0, "display data after reset");
		check_value(done_count, 0, "done pulses during reset");
		report_test("reset state", errs);

		// Plain copy of map 0.
		errs = error_count;
		load_words(0, MAP_WORDS);
		copy_map(0, 0, 1'b0, dones);
		check_value(dones, 1, "done pulses for map 0 copy");
		verify_frame(0);
		report_test("copy map 0", errs);

		// Display reads compete with the copier.
		errs = error_count;
		copy_map(2, 40, 1'b0, dones);
		check_value(dones, 1, "done pulses for map 2 copy");
		verify_frame(2);
		report_test("copy map 2 under reads", errs);

		// Second start while busy.
		errs = error_count;
		copy_map(3, 0, 1'b1, dones);
		check_value(dones, 1, "done pulses with restart");
		verify_frame(3);
		report_test("start ignored while busy", errs);

		// New contents for map 1.
		errs = error_count;
		load_words(1 * `FRAME_PIXELS, `FRAME_PIXELS);
		copy_map(1, 0, 1'b0, dones);
		check_value(dones, 1, "done pulses for reloaded map 1");
		verify_frame(1);
		report_test("reloaded map 1", errs);

		$display("Tests: %0d passed, %0d failed, %0d errors",
		         test_count - test_fails, test_fails, error_count);
		if (error_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: design/map_draw_top.sv
`timescale 1ns/10ps

`include "map_draw_settings.svh"

module map_draw_top
	import map_draw_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	input  map_wr_t            map_wr,
	input  logic               start,
	input  logic [`MAP_AW-1:0] base_addr,
	output logic               done,
	input  frame_rd_t          frame_rd,
	output pixel_t             frame_rd_data
);

	logic [`MAP_AW-1:0]   map_addr;
	pixel_t               pixel;
	logic                 mem_rdy;
	logic                 frame_rdy;
	logic                 frame_we;
	logic [`FRAME_AW-1:0] frame_addr;
	pixel_t               frame_data;

	map_memory i_map_memory (
		.clk      (clk),
		.rst_n    (rst_n),
		.map_wr   (map_wr),
		.map_addr (map_addr),
		.pixel    (pixel),
		.mem_rdy  (mem_rdy)
	);

	draw_map i_draw_map (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.base_addr  (base_addr),
		.done       (done),
		.pixel      (pixel),
		.mem_rdy    (mem_rdy),
		.mem_re     (),            // Memory reads every cycle.
		.map_addr   (map_addr),
		.frame_rdy  (frame_rdy),
		.frame_we   (frame_we),
		.frame_addr (frame_addr),
		.frame_data (frame_data)
	);

	frame_buffer i_frame_buffer (
		.clk           (clk),
		.rst_n         (rst_n),
		.frame_we      (frame_we),
		.frame_addr    (frame_addr),
		.frame_data    (frame_data),
		.frame_rdy     (frame_rdy),
		.frame_rd      (frame_rd),
		.frame_rd_data (frame_rd_data)
	);

endmodule

// File: draw_map/draw_map.sv
`timescale 1ns/10ps

`include "map_draw_settings.svh"

module draw_map
	import map_draw_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start,
	input  logic [`MAP_AW-1:0]   base_addr,
	output logic                 done,
	input  pixel_t               pixel,
	input  logic                 mem_rdy,
	output logic                 mem_re,
	output logic [`MAP_AW-1:0]   map_addr,
	input  logic                 frame_rdy,
	output logic                 frame_we,
	output logic [`FRAME_AW-1:0] frame_addr,
	output pixel_t               frame_data
);

	localparam logic [1:0] IDLE               = 2'd0;
	localparam logic [1:0] READ_MEM_PIXEL     = 2'd1;
	localparam logic [1:0] WRITE_FRAME_BUFFER = 2'd2;

	localparam logic [`FRAME_AW-1:0] LAST_PIXEL = `FRAME_AW'(`FRAME_PIXELS - 1);

	logic [1:0] state;
	logic [1:0] nxt_state;
	logic       ld_addr;    // Start accepted in IDLE.
	logic       wr_ok;      // Frame write taken this cycle.
	logic       last_pixel;

	assign last_pixel = (frame_addr == LAST_PIXEL);

	// ####################################################################
	// State and address registers
	// ####################################################################

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= nxt_state;
		end
	end

	// Map address starts at the base, frame address at zero.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			map_addr   <= '0;
			frame_addr <= '0;
		end else if (ld_addr) begin
			map_addr   <= base_addr;
			frame_addr <= '0;
		end else if (wr_ok) begin
			map_addr   <= map_addr + 1'b1;
			frame_addr <= frame_addr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_re) begin
			frame_data <= pixel;  // Held through back-pressure.
		end
	end

	// ####################################################################
	// Next state and strobes
	// ####################################################################

	always_comb begin
		nxt_state = state;
		ld_addr   = 1'b0;
		wr_ok     = 1'b0;
		mem_re    = 1'b0;
		frame_we  = 1'b0;
		done      = 1'b0;

		case (state)
			IDLE: begin
				if (start) begin
					ld_addr   = 1'b1;
					nxt_state = READ_MEM_PIXEL;
				end
			end
			READ_MEM_PIXEL: begin
				if (mem_rdy) begin
					mem_re    = 1'b1;
					nxt_state = WRITE_FRAME_BUFFER;
				end
			end
			WRITE_FRAME_BUFFER: begin
				frame_we = 1'b1;  // Stays up until accepted.
				if (frame_rdy) begin
					wr_ok = 1'b1;
					if (last_pixel) begin
						done      = 1'b1;
						nxt_state = IDLE;
					end else begin
						nxt_state = READ_MEM_PIXEL;
					end
				end
			end
			default: begin
				nxt_state = IDLE;
			end
		endcase
	end

endmodule

// File: design/frame_buffer.sv
`timescale 1ns/10ps

`include "map_draw_settings.svh"

module frame_buffer
	import map_draw_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 frame_we,
	input  logic [`FRAME_AW-1:0] frame_addr,
	input  pixel_t               frame_data,
	output logic                 frame_rdy,
	input  frame_rd_t            frame_rd,
	output pixel_t               frame_rd_data
);

	pixel_t fb [`FRAME_PIXELS];

	// ####################################################################
	// Arbitration
	// ####################################################################

	// Display reader owns the port whenever it asks.
	assign frame_rdy = ~frame_rd.en;

	// ####################################################################
	// Copier write side
	// ####################################################################

	always_ff @(posedge clk) begin
		if (frame_we && frame_rdy) begin
			fb[frame_addr] <= frame_data;
		end
	end

	// ####################################################################
	// Display read side
	// ####################################################################

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			frame_rd_data <= '0;
		end else if (frame_rd.en) begin
			frame_rd_data <= fb[frame_rd.addr];  // Valid one cycle later.
		end
	end

endmodule

// File: design/map_memory.sv
`timescale 1ns/10ps

`include "map_draw_settings.svh"

module map_memory
	import map_draw_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	input  map_wr_t            map_wr,
	input  logic [`MAP_AW-1:0] map_addr,
	output pixel_t             pixel,
	output logic               mem_rdy
);

	localparam int MAP_WORDS = `MAP_COUNT * `FRAME_PIXELS;

	pixel_t mem [MAP_WORDS];

	logic [`MAP_AW-1:0] rd_addr;  // Address behind the pixel register.
	logic               wr_d;     // Load write seen last cycle.

	// ####################################################################
	// Storage
	// ####################################################################

	always_ff @(posedge clk) begin
		if (map_wr.en) begin
			mem[map_wr.addr] <= map_wr.data;
		end
	end

	// Read every cycle with one cycle of latency.
	always_ff @(posedge clk) begin
		pixel <= mem[map_addr];
	end

	// ####################################################################
	// Ready tracking
	// ####################################################################

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_addr <= '0;
			wr_d    <= 1'b0;
		end else begin
			rd_addr <= map_addr;
			wr_d    <= map_wr.en;
		end
	end

	// A load may have changed the word just read, so wait one refresh.
	assign mem_rdy = (rd_addr == map_addr) && !wr_d;

endmodule

// File: common/map_draw_pkg.sv
`include "map_draw_settings.svh"

package map_draw_pkg;

	// ####################################################################
	// Pixel word
	// ####################################################################

	typedef struct packed {
		logic [`PIX_W/4-1:0] alpha;
		logic [`PIX_W/4-1:0] red;
		logic [`PIX_W/4-1:0] green;
		logic [`PIX_W/4-1:0] blue;
	} pixel_t;

	// ####################################################################
	// Port bundles
	// ####################################################################

	// Map load port, one word per cycle.
	typedef struct packed {
		logic                en;
		logic [`MAP_AW-1:0]  addr;
		pixel_t              data;
	} map_wr_t;

	// Display read request.
	typedef struct packed {
		logic                en;
		logic [`FRAME_AW-1:0] addr;
	} frame_rd_t;

endpackage

// File: common/map_draw_settings.svh
`ifndef MAP_DRAW_SETTINGS_SVH
`define MAP_DRAW_SETTINGS_SVH

// ####################################################################
// Frame geometry
// ####################################################################

`define FRAME_W      16                     // Pixels per line.
`define FRAME_H      12                     // Lines per frame.
`define FRAME_PIXELS (`FRAME_W * `FRAME_H)  // Words per map and per frame.

// ####################################################################
// Storage widths
// ####################################################################

`define MAP_COUNT    4   // Complete maps held.
`define MAP_AW       10  // Covers MAP_COUNT full maps.
`define FRAME_AW     8   // Covers one frame.
`define PIX_W        32  // ARGB, one byte per channel.

`endif
